// ==== src/nlb_pkg.sv ====
// NLB loopback shared definitions for register map, mode codes, widths and state encodings
`default_nettype none

package nlb_pkg;

   // ------------------------------------------------------------
   // Widths
   // ------------------------------------------------------------
   localparam int MMIO_ADDR_W = 16;
   localparam int MMIO_DATA_W = 64;
   localparam int ADDR_LMT    = 20;
   localparam int LINE_W      = 64;
   localparam int CNT_W       = 32;

   // Feature header returned at offset zero
   localparam logic [MMIO_DATA_W-1:0] DFH_VALUE = 64'h1000_0000_0000_1001;

   // ------------------------------------------------------------
   // Register byte addresses
   // ------------------------------------------------------------
   localparam logic [MMIO_ADDR_W-1:0] A_DFH        = 16'h0000;
   localparam logic [MMIO_ADDR_W-1:0] A_SCRATCH    = 16'h0100;
   localparam logic [MMIO_ADDR_W-1:0] A_SRC_ADDR   = 16'h0120;
   localparam logic [MMIO_ADDR_W-1:0] A_DST_ADDR   = 16'h0128;
   localparam logic [MMIO_ADDR_W-1:0] A_NUM_LINES  = 16'h0130;
   localparam logic [MMIO_ADDR_W-1:0] A_CTL        = 16'h0138;
   localparam logic [MMIO_ADDR_W-1:0] A_CFG        = 16'h0140;
   localparam logic [MMIO_ADDR_W-1:0] A_STATUS     = 16'h0160;
   localparam logic [MMIO_ADDR_W-1:0] A_NUM_READS  = 16'h0168;
   localparam logic [MMIO_ADDR_W-1:0] A_NUM_WRITES = 16'h0170;

   // CTL bit positions
   localparam int CTL_TEST_RST_N = 0;
   localparam int CTL_START      = 1;
   localparam int CTL_FORCE_CMP  = 2;

   // Test mode field
   typedef logic [2:0] t_mode;

   localparam t_mode M_LPBK1 = 3'd0;
   localparam t_mode M_READ  = 3'd1;
   localparam t_mode M_WRITE = 3'd2;

   // CFG word seen as a raw register or as decoded fields
   typedef union packed {
      logic [MMIO_DATA_W-1:0] raw;
      struct packed {
         logic [58:0] rsvd_hi;
         t_mode       mode;
         logic [1:0]  rsvd_lo;
      } fields;
   } t_cfg_word;

   // Sequencer state codes
   localparam logic [1:0] SEQ_IDLE  = 2'd0;
   localparam logic [1:0] SEQ_READ  = 2'd1;
   localparam logic [1:0] SEQ_WRITE = 2'd2;
   localparam logic [1:0] SEQ_DONE  = 2'd3;

   // Requestor state codes
   localparam logic [1:0] REQ_IDLE    = 2'd0;
   localparam logic [1:0] REQ_BUSY    = 2'd1;
   localparam logic [1:0] REQ_RELEASE = 2'd2;

endpackage

`default_nettype wire

// ==== src/nlb_csr.sv ====
// NLB host register block with config write lock, registered readback and test control
`timescale 1ns/1ps
`default_nettype none

module nlb_csr (
   input  logic                            Clk_400,
   input  logic                            rst,
   // Host register port
   input  logic                            mmio_wr,
   input  logic                            mmio_rd,
   input  logic [nlb_pkg::MMIO_ADDR_W-1:0] mmio_addr,
   input  logic [nlb_pkg::MMIO_DATA_W-1:0] mmio_wdata,
   output logic [nlb_pkg::MMIO_DATA_W-1:0] mmio_rdata,
   output logic                            mmio_rvalid,
   // Status from the test engine
   input  logic                            running,
   input  logic                            test_done,
   input  logic [nlb_pkg::CNT_W-1:0]       num_reads,
   input  logic [nlb_pkg::CNT_W-1:0]       num_writes,
   // Test control
   output logic                            test_rst,
   output logic                            test_go,
   output logic                            force_cmp,
   output logic [nlb_pkg::ADDR_LMT-1:0]    src_addr,
   output logic [nlb_pkg::ADDR_LMT-1:0]    dst_addr,
   output logic [nlb_pkg::CNT_W-1:0]       num_lines,
   output nlb_pkg::t_mode                  mode
);
   import nlb_pkg::*;

   logic [MMIO_DATA_W-1:0] scratch_q;
   logic [2:0]             ctl_q;
   t_cfg_word              cfg_q;
   logic [MMIO_DATA_W-1:0] rd_word;
   logic                   cfg_wr_ok;

   // Test parameters are frozen while a test runs
   assign cfg_wr_ok = mmio_wr && !running;

   // ------------------------------------------------------------
   // Register writes
   // ------------------------------------------------------------
   always_ff @(posedge Clk_400) begin
      if (rst) begin
         scratch_q <= '0;
         src_addr  <= '0;
         dst_addr  <= '0;
         num_lines <= '0;
         ctl_q     <= '0;
         cfg_q     <= '0;
      end else begin
         // Always writable
         if (mmio_wr && mmio_addr == A_SCRATCH) begin
            scratch_q <= mmio_wdata;
         end
         if (mmio_wr && mmio_addr == A_CTL) begin
            ctl_q <= mmio_wdata[2:0];
         end
         // Locked while running
         if (cfg_wr_ok) begin
            case (mmio_addr)
               A_SRC_ADDR:  src_addr  <= mmio_wdata[ADDR_LMT-1:0];
               A_DST_ADDR:  dst_addr  <= mmio_wdata[ADDR_LMT-1:0];
               A_NUM_LINES: num_lines <= mmio_wdata[CNT_W-1:0];
               A_CFG:       cfg_q.raw <= mmio_wdata;
               default:     ;
            endcase
         end
      end
   end

   // ------------------------------------------------------------
   // Control outputs
   // ------------------------------------------------------------
   // Engine is held in reset until software sets the active low bit
   assign test_rst  = rst || !ctl_q[CTL_TEST_RST_N];
   assign test_go   = ctl_q[CTL_START];
   assign force_cmp = ctl_q[CTL_FORCE_CMP];
   assign mode      = cfg_q.fields.mode;

   // ------------------------------------------------------------
   // Readback
   // ------------------------------------------------------------
   // Unknown addresses read as zero
   always_comb begin
      case (mmio_addr)
         A_DFH:        rd_word = DFH_VALUE;
         A_SCRATCH:    rd_word = scratch_q;
         A_SRC_ADDR:   rd_word = MMIO_DATA_W'(src_addr);
         A_DST_ADDR:   rd_word = MMIO_DATA_W'(dst_addr);
         A_NUM_LINES:  rd_word = MMIO_DATA_W'(num_lines);
         A_CTL:        rd_word = MMIO_DATA_W'(ctl_q);
         A_CFG:        rd_word = cfg_q.raw;
         // Bit 0 done, bit 1 running
         A_STATUS:     rd_word = MMIO_DATA_W'({running, test_done});
         A_NUM_READS:  rd_word = MMIO_DATA_W'(num_reads);
         A_NUM_WRITES: rd_word = MMIO_DATA_W'(num_writes);
         default:      rd_word = '0;
      endcase
   end

   // Fixed one cycle read latency
   always_ff @(posedge Clk_400) begin
      if (rst) begin
         mmio_rvalid <= 1'b0;
      end else begin
         mmio_rvalid <= mmio_rd;
      end
   end

   // Data word only matters when rvalid is high
   always_ff @(posedge Clk_400) begin
      if (mmio_rd) begin
         mmio_rdata <= rd_word;
      end
   end

endmodule

`default_nettype wire

// ==== src/lpbk_sequencer.sv ====
// NLB test mode sequencer that walks the lines and issues read and write operations
`timescale 1ns/1ps
`default_nettype none

module lpbk_sequencer (
   input  logic                         Clk_400,
   input  logic                         test_rst,
   input  logic                         test_go,
   input  logic                         force_cmp,
   input  logic [nlb_pkg::ADDR_LMT-1:0] src_addr,
   input  logic [nlb_pkg::ADDR_LMT-1:0] dst_addr,
   input  logic [nlb_pkg::CNT_W-1:0]    num_lines,
   input  nlb_pkg::t_mode               mode,
   // Operation towards the requestor
   output logic                         op_valid,
   output logic                         op_wr,
   output logic [nlb_pkg::ADDR_LMT-1:0] op_addr,
   output logic [nlb_pkg::LINE_W-1:0]   op_wdata,
   input  logic                         op_done,
   input  logic [nlb_pkg::LINE_W-1:0]   op_rdata,
   // Status
   output logic                         running,
   output logic                         test_done
);
   import nlb_pkg::*;

   logic [1:0]          state;
   logic [CNT_W-1:0]    idx;
   logic [CNT_W-1:0]    idx_next;
   logic [LINE_W-1:0]   rd_line;
   logic [ADDR_LMT-1:0] line_off;
   logic                mode_ok;
   logic                finish;

   // Only LPBK1, READ and WRITE are implemented
   assign mode_ok  = (mode == M_LPBK1) || (mode == M_READ) || (mode == M_WRITE);
   assign idx_next = idx + 1'b1;
   assign line_off = idx[ADDR_LMT-1:0];

   // Stop after the last line or on a forced completion
   assign finish = (idx_next == num_lines) || force_cmp;

   // ------------------------------------------------------------
   // Line walker FSM
   // ------------------------------------------------------------
   always_ff @(posedge Clk_400) begin
      if (test_rst) begin
         state <= SEQ_IDLE;
         idx   <= '0;
      end else begin
         case (state)
            SEQ_IDLE: begin
               if (test_go) begin
                  idx <= '0;
                  // Nothing to do for bad modes or zero lines
                  if (!mode_ok || num_lines == '0) begin
                     state <= SEQ_DONE;
                  end else if (mode == M_WRITE) begin
                     state <= SEQ_WRITE;
                  end else begin
                     state <= SEQ_READ;
                  end
               end
            end
            SEQ_READ: begin
               if (op_done) begin
                  // LPBK1 always writes back the line it just read
                  if (mode == M_LPBK1) begin
                     state <= SEQ_WRITE;
                  end else if (finish) begin
                     state <= SEQ_DONE;
                  end else begin
                     idx <= idx_next;
                  end
               end
            end
            SEQ_WRITE: begin
               if (op_done) begin
                  if (finish) begin
                     state <= SEQ_DONE;
                  end else begin
                     idx <= idx_next;
                     if (mode == M_LPBK1) begin
                        state <= SEQ_READ;
                     end
                  end
               end
            end
            // Done holds until the next test reset
            default: state <= state;
         endcase
      end
   end

   // Latest read line kept for the LPBK1 write
   always_ff @(posedge Clk_400) begin
      if (state == SEQ_READ && op_done) begin
         rd_line <= op_rdata;
      end
   end

   // ------------------------------------------------------------
   // Operation and status outputs
   // ------------------------------------------------------------
   assign op_valid = (state == SEQ_READ) || (state == SEQ_WRITE);
   assign op_wr    = (state == SEQ_WRITE);
   assign op_addr  = op_wr ? dst_addr + line_off : src_addr + line_off;

   // WRITE mode writes the line index as its pattern
   assign op_wdata = (mode == M_WRITE) ? LINE_W'(idx) : rd_line;

   assign running   = op_valid;
   assign test_done = (state == SEQ_DONE);

endmodule

`default_nettype wire

// ==== src/mem_requestor.sv ====
// NLB memory requestor as a four-phase req/ack master with read and write counters
`timescale 1ns/1ps
`default_nettype none

module mem_requestor (
   input  logic                         Clk_400,
   input  logic                         test_rst,
   // Operation from the sequencer
   input  logic                         op_valid,
   input  logic                         op_wr,
   input  logic [nlb_pkg::ADDR_LMT-1:0] op_addr,
   input  logic [nlb_pkg::LINE_W-1:0]   op_wdata,
   output logic                         op_done,
   output logic [nlb_pkg::LINE_W-1:0]   op_rdata,
   // Memory port
   output logic                         mem_req,
   output logic                         mem_wr,
   output logic [nlb_pkg::ADDR_LMT-1:0] mem_addr,
   output logic [nlb_pkg::LINE_W-1:0]   mem_wdata,
   input  logic                         mem_ack,
   input  logic [nlb_pkg::LINE_W-1:0]   mem_rdata,
   // Activity counters
   output logic [nlb_pkg::CNT_W-1:0]    num_reads,
   output logic [nlb_pkg::CNT_W-1:0]    num_writes
);
   import nlb_pkg::*;

   logic [1:0] state;
   logic       launch;
   logic       ack_seen;

   // New request only once the previous ack has dropped
   assign launch   = (state == REQ_IDLE) && op_valid && !mem_ack;
   assign ack_seen = (state == REQ_BUSY) && mem_ack;

   // ------------------------------------------------------------
   // Handshake FSM
   // ------------------------------------------------------------
   always_ff @(posedge Clk_400) begin
      if (test_rst) begin
         state      <= REQ_IDLE;
         op_done    <= 1'b0;
         num_reads  <= '0;
         num_writes <= '0;
      end else begin
         op_done <= 1'b0;
         case (state)
            REQ_IDLE: begin
               if (launch) begin
                  state <= REQ_BUSY;
               end
            end
            REQ_BUSY: begin
               if (mem_ack) begin
                  // Drop req next cycle and report completion
                  state   <= REQ_RELEASE;
                  op_done <= 1'b1;
                  if (mem_wr) begin
                     num_writes <= num_writes + 1'b1;
                  end else begin
                     num_reads <= num_reads + 1'b1;
                  end
               end
            end
            REQ_RELEASE: begin
               // Wait for the memory to lower ack
               if (!mem_ack) begin
                  state <= REQ_IDLE;
               end
            end
            default: state <= REQ_IDLE;
         endcase
      end
   end

   // Request fields frozen for the whole req phase
   always_ff @(posedge Clk_400) begin
      if (launch) begin
         mem_wr    <= op_wr;
         mem_addr  <= op_addr;
         mem_wdata <= op_wdata;
      end
      if (ack_seen && !mem_wr) begin
         op_rdata <= mem_rdata;
      end
   end

   assign mem_req = (state == REQ_BUSY);

endmodule

`default_nettype wire

// ==== src/nlb_lpbk.sv ====
// NLB loopback top level joining the register block, test sequencer and memory requestor
`timescale 1ns/1ps
`default_nettype none

module nlb_lpbk (
   input  logic                            Clk_400,
   input  logic                            rst,
   // Host register port
   input  logic                            mmio_wr,
   input  logic                            mmio_rd,
   input  logic [nlb_pkg::MMIO_ADDR_W-1:0] mmio_addr,
   input  logic [nlb_pkg::MMIO_DATA_W-1:0] mmio_wdata,
   output logic [nlb_pkg::MMIO_DATA_W-1:0] mmio_rdata,
   output logic                            mmio_rvalid,
   // Memory port
   output logic                            mem_req,
   output logic                            mem_wr,
   output logic [nlb_pkg::ADDR_LMT-1:0]    mem_addr,
   output logic [nlb_pkg::LINE_W-1:0]      mem_wdata,
   input  logic                            mem_ack,
   input  logic [nlb_pkg::LINE_W-1:0]      mem_rdata,
   output logic                            test_done
);
   import nlb_pkg::*;

   // ------------------------------------------------------------
   // Register block to engine
   // ------------------------------------------------------------
   logic                test_rst;
   logic                test_go;
   logic                force_cmp;
   logic [ADDR_LMT-1:0] src_addr;
   logic [ADDR_LMT-1:0] dst_addr;
   logic [CNT_W-1:0]    num_lines;
   t_mode               mode;

   // Engine status back to registers
   logic                running;
   logic [CNT_W-1:0]    num_reads;
   logic [CNT_W-1:0]    num_writes;

   // Sequencer to requestor
   logic                op_valid;
   logic                op_wr;
   logic [ADDR_LMT-1:0] op_addr;
   logic [LINE_W-1:0]   op_wdata;
   logic                op_done;
   logic [LINE_W-1:0]   op_rdata;

   nlb_csr i_nlb_csr (
      .Clk_400     (Clk_400),
      .rst         (rst),
      .mmio_wr     (mmio_wr),
      .mmio_rd     (mmio_rd),
      .mmio_addr   (mmio_addr),
      .mmio_wdata  (mmio_wdata),
      .mmio_rdata  (mmio_rdata),
      .mmio_rvalid (mmio_rvalid),
      .running     (running),
      .test_done   (test_done),
      .num_reads   (num_reads),
      .num_writes  (num_writes),
      .test_rst    (test_rst),
      .test_go     (test_go),
      .force_cmp   (force_cmp),
      .src_addr    (src_addr),
      .dst_addr    (dst_addr),
      .num_lines   (num_lines),
      .mode        (mode)
   );

   // Plays the arbiter and test mode role
   lpbk_sequencer i_lpbk_sequencer (
      .Clk_400   (Clk_400),
      .test_rst  (test_rst),
      .test_go   (test_go),
      .force_cmp (force_cmp),
      .src_addr  (src_addr),
      .dst_addr  (dst_addr),
      .num_lines (num_lines),
      .mode      (mode),
      .op_valid  (op_valid),
      .op_wr     (op_wr),
      .op_addr   (op_addr),
      .op_wdata  (op_wdata),
      .op_done   (op_done),
      .op_rdata  (op_rdata),
      .running   (running),
      .test_done (test_done)
   );

   mem_requestor i_mem_requestor (
      .Clk_400    (Clk_400),
      .test_rst   (test_rst),
      .op_valid   (op_valid),
      .op_wr      (op_wr),
      .op_addr    (op_addr),
      .op_wdata   (op_wdata),
      .op_done    (op_done),
      .op_rdata   (op_rdata),
      .mem_req    (mem_req),
      .mem_wr     (mem_wr),
      .mem_addr   (mem_addr),
      .mem_wdata  (mem_wdata),
      .mem_ack    (mem_ack),
      .mem_rdata  (mem_rdata),
      .num_reads  (num_reads),
      .num_writes (num_writes)
   );

endmodule

`default_nettype wire

// ==== testbench/nlb_lpbk_chk.sv ====
// NLB loopback protocol checker for the four-phase memory port and host read latency
`timescale 1ns/1ps
`default_nettype none

module nlb_lpbk_chk (
   input logic                         Clk_400,
   input logic                         rst,
   input logic                         mmio_rd,
   input logic                         mmio_rvalid,
   input logic                         mem_req,
   input logic                         mem_wr,
   input logic [nlb_pkg::ADDR_LMT-1:0] mem_addr,
   input logic [nlb_pkg::LINE_W-1:0]   mem_wdata,
   input logic                         mem_ack
);

   // ------------------------------------------------------------
   // Memory handshake
   // ------------------------------------------------------------
   // Request stays up until acknowledged
   a_req_hold: assert property (@(posedge Clk_400) disable iff (rst)
      mem_req && !mem_ack |=> mem_req)
      else $error("mem_req dropped before mem_ack");

   // Fields frozen while req is high
   a_req_stable: assert property (@(posedge Clk_400) disable iff (rst)
      mem_req |=> !mem_req || ($stable(mem_addr) && $stable(mem_wr) && $stable(mem_wdata)))
      else $error("memory request fields changed while mem_req high");

   // Ack was low on the edge that raised req
   a_req_rise: assert property (@(posedge Clk_400) disable iff (rst)
      $rose(mem_req) |-> !$past(mem_ack))
      else $error("mem_req rose while mem_ack high");

   // Host read data one cycle after the strobe
   a_rvalid: assert property (@(posedge Clk_400) disable iff (rst)
      mmio_rd |=> mmio_rvalid)
      else $error("mmio_rvalid missing after mmio_rd");

   a_rvalid_src: assert property (@(posedge Clk_400) disable iff (rst)
      mmio_rvalid |-> $past(mmio_rd))
      else $error("mmio_rvalid without a prior mmio_rd");

endmodule

bind nlb_lpbk nlb_lpbk_chk i_nlb_lpbk_chk (
   .Clk_400     (Clk_400),
   .rst         (rst),
   .mmio_rd     (mmio_rd),
   .mmio_rvalid (mmio_rvalid),
   .mem_req     (mem_req),
   .mem_wr      (mem_wr),
   .mem_addr    (mem_addr),
   .mem_wdata   (mem_wdata),
   .mem_ack     (mem_ack)
);

`default_nettype wire

// ==== testbench/tb_nlb_lpbk.sv ====
// NLB loopback testbench with a four-phase memory model, host register tasks and a test table
`timescale 1ns/1ps
`default_nettype none

module tb_nlb_lpbk;
   import nlb_pkg::*;

   // Expected destination contents per row
   localparam logic [1:0] K_COPY  = 2'd0;
   localparam logic [1:0] K_INDEX = 2'd1;
   localparam logic [1:0] K_SAME  = 2'd2;
   localparam int NUM_ROWS = 6;
   localparam int MARGIN   = 1000;
   localparam int FORCE_AT = 40;

   typedef struct packed {
      t_mode       mode;
      logic [19:0] src;
      logic [19:0] dst;
      logic [31:0] lines;
      logic        force_c;
      logic        lock_chk;
      logic [31:0] exp_rd;
      logic [31:0] exp_wr;
      logic [1:0]  kind;
   } row_t;

   logic                   Clk_400;
   logic                   rst;
   logic                   mmio_wr;
   logic                   mmio_rd;
   logic [MMIO_ADDR_W-1:0] mmio_addr;
   logic [MMIO_DATA_W-1:0] mmio_wdata;
   logic [MMIO_DATA_W-1:0] mmio_rdata;
   logic                   mmio_rvalid;
   logic                   mem_req;
   logic                   mem_wr;
   logic [ADDR_LMT-1:0]    mem_addr;
   logic [LINE_W-1:0]      mem_wdata;
   logic                   mem_ack;
   logic [LINE_W-1:0]      mem_rdata;
   logic                   test_done;

   logic [LINE_W-1:0]      mem [0:4095];
   int                     req_seen;
   int                     wr_seen;
   int                     errors;

   nlb_lpbk i_nlb_lpbk (
      .Clk_400     (Clk_400),
      .rst         (rst),
      .mmio_wr     (mmio_wr),
      .mmio_rd     (mmio_rd),
      .mmio_addr   (mmio_addr),
      .mmio_wdata  (mmio_wdata),
      .mmio_rdata  (mmio_rdata),
      .mmio_rvalid (mmio_rvalid),
      .mem_req     (mem_req),
      .mem_wr      (mem_wr),
      .mem_addr    (mem_addr),
      .mem_wdata   (mem_wdata),
      .mem_ack     (mem_ack),
      .mem_rdata   (mem_rdata),
      .test_done   (test_done)
   );

   initial Clk_400 = 1'b0;
   always #5 Clk_400 = ~Clk_400;

   // ------------------------------------------------------------
   // Stimulus table and helpers
   // ------------------------------------------------------------
   function automatic row_t table_row(input int i);
      case (i)
         0: return '{M_LPBK1, 20'h000, 20'h400, 32'd16, 1'b0, 1'b1, 32'd16, 32'd16, K_COPY};
         1: return '{M_READ,  20'h100, 20'h500, 32'd12, 1'b0, 1'b0, 32'd12, 32'd0,  K_SAME};
         2: return '{M_WRITE, 20'h000, 20'h600, 32'd20, 1'b0, 1'b0, 32'd0,  32'd20, K_INDEX};
         // Long copy cut short by forced completion
         3: return '{M_LPBK1, 20'h200, 20'h800, 32'd64, 1'b1, 1'b0, 32'd0,  32'd0,  K_COPY};
         // Unsupported mode
         4: return '{3'd5,    20'h000, 20'h900, 32'd8,  1'b0, 1'b0, 32'd0,  32'd0,  K_SAME};
         default: return '{M_LPBK1, 20'h000, 20'hA00, 32'd0, 1'b0, 1'b0, 32'd0, 32'd0, K_SAME};
      endcase
   endfunction

   // Preload pattern, a function of the full line address
   function automatic logic [63:0] fill_value(input logic [19:0] a);
      return {44'h0, a} * 64'h0000_0000_9E37_79B9 + 64'h0123_4567_0000_0000;
   endfunction

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      if (got !== exp) begin
         $display("ERROR %s: got 0x%h, expected 0x%h", name, got, exp);
         errors++;
      end
   endtask

   // Host bus tasks, called on a falling edge
   task automatic host_write(input logic [15:0] addr, input logic [63:0] data);
      mmio_wr    = 1'b1;
      mmio_addr  = addr;
      mmio_wdata = data;
      @(negedge Clk_400);
      mmio_wr    = 1'b0;
   endtask

   task automatic host_read(input logic [15:0] addr, output logic [63:0] data);
      mmio_rd   = 1'b1;
      mmio_addr = addr;
      @(negedge Clk_400);
      mmio_rd   = 1'b0;
      // Data due exactly one cycle after the strobe
      if (mmio_rvalid !== 1'b1) begin
         $display("Register read of 0x%h returned no valid data after one cycle", addr);
         errors++;
      end
      data = mmio_rdata;
   endtask

   task automatic wait_done(input int limit);
      int cycles;
      cycles = 0;
      while (test_done !== 1'b1 && cycles < limit) begin
         @(negedge Clk_400);
         cycles++;
      end
      if (test_done !== 1'b1) begin
         $display("Test never signalled completion within %0d cycles", limit);
         errors++;
      end
   endtask

   // ------------------------------------------------------------
   // Memory model, four-phase slave with random ack delay
   // ------------------------------------------------------------
   initial begin
      int ack_wait;
      void'($urandom(57));
      mem_ack   = 1'b0;
      mem_rdata = '0;
      req_seen  = 0;
      wr_seen   = 0;
      for (int a = 0; a < 4096; a++) begin
         mem[a[11:0]] = fill_value(20'(a));
      end
      ack_wait = int'($urandom % 6);
      forever begin
         @(negedge Clk_400);
         if (mem_req === 1'b1 && !mem_ack) begin
            if (ack_wait == 0) begin
               mem_ack = 1'b1;
               req_seen++;
               if (mem_wr) begin
                  mem[mem_addr[11:0]] = mem_wdata;
                  wr_seen++;
               end else begin
                  mem_rdata = mem[mem_addr[11:0]];
               end
            end else begin
               ack_wait--;
            end
         end else if (mem_req !== 1'b1 && mem_ack) begin
            mem_ack  = 1'b0;
            ack_wait = int'($urandom % 6);
         end
      end
   end

   // Watchdog sized from the total line count
   initial begin
      int   total;
      row_t wr;
      total = 0;
      for (int i = 0; i < NUM_ROWS; i++) begin
         wr = table_row(i);
         total += int'(wr.lines);
      end
      repeat (total * 20 + MARGIN) @(posedge Clk_400);
      $display("Timeout: run did not finish within %0d cycles", total * 20 + MARGIN);
      $display("Simulation FAILED");
      $finish;
   end

   // ------------------------------------------------------------
   // Main sequence
   // ------------------------------------------------------------
   initial begin
      row_t        r;
      logic [63:0] rd;
      logic [63:0] nrd;
      logic [63:0] nwr;
      logic [63:0] exp;
      logic [19:0] a;
      logic [15:0] zero_regs [8];
      int          err_base;
      int          req_base;
      int          wr_base;
      int          n_chk;
      int          failed;
      rst        = 1'b1;
      mmio_wr    = 1'b0;
      mmio_rd    = 1'b0;
      mmio_addr  = '0;
      mmio_wdata = '0;
      errors     = 0;
      failed     = 0;
      zero_regs  = '{A_SRC_ADDR, A_DST_ADDR, A_NUM_LINES, A_CTL, A_CFG, A_STATUS,
                     A_NUM_READS, A_NUM_WRITES};
      repeat (2) @(negedge Clk_400);
      rst = 1'b0;

      // Register sanity after reset
      err_base = errors;
      check_value("test_done", 64'(test_done), 64'd0);
      check_value("mem_req", 64'(mem_req), 64'd0);
      check_value("mmio_rvalid", 64'(mmio_rvalid), 64'd0);
      host_read(A_DFH, rd);
      check_value("DFH", rd, DFH_VALUE);
      foreach (zero_regs[k]) begin
         host_read(zero_regs[k], rd);
         check_value($sformatf("reg[0x%h]", zero_regs[k]), rd, 64'd0);
      end
      host_write(A_SCRATCH, 64'hDEAD_BEEF_0BAD_F00D);
      host_read(A_SCRATCH, rd);
      check_value("SCRATCH", rd, 64'hDEAD_BEEF_0BAD_F00D);
      if (errors != err_base) failed++;
      $display("Test 0 registers: %s", (errors == err_base) ? "ok" : "mismatch");

      for (int t = 0; t < NUM_ROWS; t++) begin
         r        = table_row(t);
         err_base = errors;
         req_base = req_seen;
         wr_base  = wr_seen;
         host_write(A_SRC_ADDR, 64'(r.src));
         host_write(A_DST_ADDR, 64'(r.dst));
         host_write(A_NUM_LINES, 64'(r.lines));
         host_write(A_CFG, {59'd0, r.mode, 2'b00});
         host_write(A_CTL, 64'h3);

         if (r.lock_chk) begin
            // Engine leaves idle one cycle after the start bit lands
            @(negedge Clk_400);
            host_read(A_STATUS, rd);
            check_value("STATUS.running", 64'(rd[1]), 64'd1);
            host_write(A_NUM_LINES, 64'd99);
            host_write(A_DST_ADDR, 64'h777);
            host_read(A_NUM_LINES, rd);
            check_value("NUM_LINES locked", rd, 64'(r.lines));
            host_read(A_DST_ADDR, rd);
            check_value("DST_ADDR locked", rd, 64'(r.dst));
         end
         if (r.force_c) begin
            repeat (FORCE_AT) @(negedge Clk_400);
            host_write(A_CTL, 64'h7);
         end

         wait_done(int'(r.lines) * 40 + 200);
         host_read(A_STATUS, rd);
         check_value("STATUS.done", 64'(rd[0]), 64'd1);
         host_read(A_NUM_READS, nrd);
         host_read(A_NUM_WRITES, nwr);

         if (r.force_c) begin
            // Counters match the traffic the memory model answered
            check_value("NUM_WRITES", nwr, 64'(wr_seen - wr_base));
            check_value("NUM_READS", nrd, 64'((req_seen - req_base) - (wr_seen - wr_base)));
            if (nrd >= 64'(r.lines) || nwr >= 64'(r.lines)) begin
               $display("Forced run did not stop early: %0d reads, %0d writes", nrd, nwr);
               errors++;
            end
            n_chk = wr_seen - wr_base;
         end else begin
            check_value("NUM_READS", nrd, 64'(r.exp_rd));
            check_value("NUM_WRITES", nwr, 64'(r.exp_wr));
            check_value("mem requests", 64'(req_seen - req_base), 64'(r.exp_rd + r.exp_wr));
            n_chk = int'(r.lines);
         end

         for (int i = 0; i < n_chk; i++) begin
            a = r.dst + 20'(i);
            case (r.kind)
               K_COPY:  exp = fill_value(r.src + 20'(i));
               K_INDEX: exp = 64'(i);
               default: exp = fill_value(a);
            endcase
            check_value($sformatf("mem[0x%h]", a), mem[a[11:0]], exp);
         end

         // Test reset, then parameters are writable again
         host_write(A_CTL, 64'h0);
         if (r.lock_chk) begin
            host_write(A_NUM_LINES, 64'd99);
            host_write(A_DST_ADDR, 64'h777);
            host_read(A_NUM_LINES, rd);
            check_value("NUM_LINES unlocked", rd, 64'd99);
            host_read(A_DST_ADDR, rd);
            check_value("DST_ADDR unlocked", rd, 64'h777);
         end
         if (errors != err_base) failed++;
         $display("Test %0d mode %0d lines %0d: %s", t + 1, r.mode, r.lines,
                  (errors == err_base) ? "ok" : "mismatch");
      end

      $display("Tests run: %0d, failed: %0d, errors: %0d", NUM_ROWS + 1, failed, errors);
      if (errors == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== nlb_lpbk.f ====
src/nlb_pkg.sv
src/nlb_csr.sv
src/lpbk_sequencer.sv
src/mem_requestor.sv
src/nlb_lpbk.sv
testbench/nlb_lpbk_chk.sv
testbench/tb_nlb_lpbk.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the NLB loopback testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module tb_nlb_lpbk \
   -f nlb_lpbk.f \
   -o tb_nlb_lpbk_sim > compile.log 2>&1 \
   && ./obj_dir/tb_nlb_lpbk_sim > sim.log 2>&1 \
   || { echo "Build or simulation run failed"; cat compile.log sim.log 2>/dev/null; exit 1; }

cat sim.log

grep -q "Simulation FAILED" sim.log && { echo "Result: failure"; exit 1; } \
   || { echo "Result: success"; exit 0; }
